//--- rtl/video_pkg.sv
package video_pkg;

    typedef logic [7:0] pixel_t;   // raw grey sample

    typedef struct packed {
        pixel_t r;
        pixel_t g;
        pixel_t b;
    } rgb_t;

    // all fields active high
    typedef struct packed {
        logic vs;
        logic hs;
        logic de;
        logic sof;   // first cycle of vs only
    } vtc_sync_t;

    localparam int WB_ADR_W = 24;   // word address width
    localparam int WORD_W = 32;
    localparam int PIX_PER_WORD = 4;   // msb byte goes out first

    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic [WB_ADR_W-1:0] adr;   // word address
    } wb_req_t;

    typedef logic [4:0] key_state_t;   // press count, wraps at 32

    localparam pixel_t DEFAULT_THRESHOLD = 8'd80;   // used below 8 presses

endpackage

//--- rtl/video_timing_gen.sv
`timescale 1ns/1ps

module video_timing_gen import video_pkg::*; #(
    parameter int H_ACTIVE = 1920,
    parameter int H_FP     = 88,
    parameter int H_SYNC   = 44,
    parameter int H_BP     = 148,
    parameter int V_ACTIVE = 1080,
    parameter int V_FP     = 4,
    parameter int V_SYNC   = 5,
    parameter int V_BP     = 36
) (
    input  logic      vtc_clk,
    input  logic      arst_n_i,
    output vtc_sync_t sync_o
);

    localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;
    localparam int H_CNT_W = $clog2(H_TOTAL);
    localparam int V_CNT_W = $clog2(V_TOTAL);
    localparam int HS_START = H_ACTIVE + H_FP;
    localparam int VS_START = V_ACTIVE + V_FP;

    logic [H_CNT_W-1:0] h_cnt;
    logic [V_CNT_W-1:0] v_cnt;
    logic               h_last;
    logic               v_last;
    vtc_sync_t          sync_d;

    assign h_last = (int'(h_cnt) == H_TOTAL - 1);
    assign v_last = (int'(v_cnt) == V_TOTAL - 1);

    always_ff @(posedge vtc_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
            v_cnt <= v_last ? '0 : v_cnt + 1'b1;   // frame wrap
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // window decode from the current counter position
    always_comb begin
        sync_d.de  = (int'(h_cnt) < H_ACTIVE) && (int'(v_cnt) < V_ACTIVE);
        sync_d.hs  = (int'(h_cnt) >= HS_START) && (int'(h_cnt) < HS_START + H_SYNC);
        sync_d.vs  = (int'(v_cnt) >= VS_START) && (int'(v_cnt) < VS_START + V_SYNC);
        sync_d.sof = (int'(v_cnt) == VS_START) && (h_cnt == '0);
    end

    always_ff @(posedge vtc_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync_o <= '0;
        end else begin
            sync_o <= sync_d;   // h=0, v=0 comes out first
        end
    end

endmodule

//--- rtl/pixel_fetch.sv
`timescale 1ns/1ps

module pixel_fetch import video_pkg::*; #(
    parameter int FIFO_DEPTH  = 4,
    parameter int FRAME_WORDS = 1920 * 1080 / PIX_PER_WORD
) (
    input  logic              vtc_clk,
    input  logic              arst_n_i,
    input  vtc_sync_t         sync_i,
    input  logic [WORD_W-1:0] wb_dat_i,
    input  logic              wb_ack_i,
    output wb_req_t           wb_req_o,
    output vtc_sync_t         sync_o,
    output pixel_t            pix_o,
    output logic              underrun_o
);

    localparam int PTR_W  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);
    localparam int BYTE_W = $clog2(PIX_PER_WORD);

    logic [WORD_W-1:0] fifo_mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  fifo_cnt;
    logic [WB_ADR_W:0] fetch_cnt;   // words requested this frame
    logic [BYTE_W-1:0] byte_cnt;
    logic              running;     // set by the first sof
    logic              discard;     // drop data of a read left over at sof
    logic              fifo_empty;
    logic              push;
    logic              pop;
    logic              issue;
    logic [WORD_W-1:0] head;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (int'(ptr) == FIFO_DEPTH - 1) ? '0 : ptr + 1'b1;
    endfunction

    assign fifo_empty = (fifo_cnt == '0);
    assign head       = fifo_mem[rd_ptr];
    assign push       = wb_req_o.cyc && wb_ack_i && !discard;
    assign pop        = sync_i.de && (int'(byte_cnt) == PIX_PER_WORD - 1) && !fifo_empty;

    // one read at a time, only after the bus has been idle for a cycle
    assign issue = running && !wb_req_o.cyc && !sync_i.sof
                   && (int'(fifo_cnt) < FIFO_DEPTH) && (int'(fetch_cnt) < FRAME_WORDS);

    always_ff @(posedge vtc_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_req_o  <= '0;
            fetch_cnt <= '0;
            running   <= 1'b0;
            discard   <= 1'b0;
        end else begin
            if (wb_req_o.cyc && wb_ack_i) begin
                wb_req_o.cyc <= 1'b0;
                wb_req_o.stb <= 1'b0;
            end else if (issue) begin
                wb_req_o.cyc <= 1'b1;
                wb_req_o.stb <= 1'b1;
                wb_req_o.adr <= fetch_cnt[WB_ADR_W-1:0];
                fetch_cnt    <= fetch_cnt + 1'b1;
            end
            if (sync_i.sof) begin
                running   <= 1'b1;
                fetch_cnt <= '0;   // restart at word 0
                discard   <= wb_req_o.cyc && !wb_ack_i;
            end else if (wb_req_o.cyc && wb_ack_i) begin
                discard <= 1'b0;
            end
        end
    end

    always_ff @(posedge vtc_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
        end else if (sync_i.sof) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            fifo_cnt <= fifo_cnt + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge vtc_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            byte_cnt   <= '0;
            underrun_o <= 1'b0;
            sync_o     <= '0;
        end else begin
            byte_cnt <= sync_i.de ? byte_cnt + 1'b1 : '0;
            if (sync_i.sof) begin
                underrun_o <= 1'b0;
            end else if (running && sync_i.de && fifo_empty) begin
                underrun_o <= 1'b1;   // sticky until next frame
            end
            sync_o <= sync_i;
        end
    end

    always_ff @(posedge vtc_clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= wb_dat_i;
        end
        if (sync_i.de && !fifo_empty) begin
            pix_o <= head[(PIX_PER_WORD - 1 - int'(byte_cnt)) * 8 +: 8];
        end else begin
            pix_o <= '0;   // blank or starved
        end
    end

endmodule

//--- rtl/threshold_ctrl.sv
`timescale 1ns/1ps

module threshold_ctrl import video_pkg::*; (
    input  logic   vtc_clk,
    input  logic   arst_n_i,
    input  logic   key_i,
    output pixel_t threshold_o
);

    logic [1:0] key_sync;   // two flop synchroniser
    logic       key_q;
    logic       key_rise;
    key_state_t press_cnt;

    assign key_rise = key_sync[1] && !key_q;

    always_ff @(posedge vtc_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            key_sync  <= '0;
            key_q     <= 1'b0;
            press_cnt <= '0;
        end else begin
            key_sync <= {key_sync[0], key_i};
            key_q    <= key_sync[1];
            if (key_rise) begin
                press_cnt <= press_cnt + 1'b1;   // wraps at 32
            end
        end
    end

    // 8 presses or more step the threshold in units of 8
    assign threshold_o = (press_cnt < 5'd8) ? DEFAULT_THRESHOLD : {press_cnt, 3'b000};

endmodule

//--- rtl/edge_overlay.sv
`timescale 1ns/1ps

module edge_overlay import video_pkg::*; (
    input  logic      vtc_clk,
    input  logic      arst_n_i,
    input  vtc_sync_t sync_i,
    input  pixel_t    pix_i,
    input  pixel_t    threshold_i,
    output vtc_sync_t sync_o,
    output rgb_t      rgb_o
);

    pixel_t thr_q;    // held for the whole frame
    pixel_t pix_d1;
    pixel_t pix_d2;
    pixel_t grad;
    pixel_t grey;

    // horizontal gradient over a two pixel span
    always_comb begin
        grad = (pix_i > pix_d2) ? pix_i - pix_d2 : pix_d2 - pix_i;
        grey = (grad > thr_q) ? 8'hff : pix_i;
    end

    always_ff @(posedge vtc_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            thr_q  <= DEFAULT_THRESHOLD;
            pix_d1 <= '0;
            pix_d2 <= '0;
            sync_o <= '0;
            rgb_o  <= '0;
        end else begin
            if (sync_i.sof) begin
                thr_q <= threshold_i;
            end
            if (sync_i.de) begin
                pix_d1 <= pix_i;
                pix_d2 <= pix_d1;
            end else begin
                pix_d1 <= '0;   // each line starts with empty history
                pix_d2 <= '0;
            end
            sync_o <= sync_i;
            if (sync_i.de) begin
                rgb_o.r <= grey;
                rgb_o.g <= grey;
                rgb_o.b <= grey;
            end else begin
                rgb_o <= '0;
            end
        end
    end

endmodule

//--- rtl/edge_video_top.sv
`timescale 1ns/1ps

module edge_video_top import video_pkg::*; #(
    parameter int H_ACTIVE   = 1920,
    parameter int H_FP       = 88,
    parameter int H_SYNC     = 44,
    parameter int H_BP       = 148,
    parameter int V_ACTIVE   = 1080,
    parameter int V_FP       = 4,
    parameter int V_SYNC     = 5,
    parameter int V_BP       = 36,
    parameter int FIFO_DEPTH = 4
) (
    input  logic              vtc_clk,
    input  logic              arst_n_i,
    input  logic              key_i,
    input  logic [WORD_W-1:0] wb_dat_i,
    input  logic              wb_ack_i,
    output wb_req_t           wb_req_o,
    output vtc_sync_t         video_sync_o,
    output rgb_t              video_rgb_o,
    output logic              underrun_o
);

    localparam int FRAME_WORDS = H_ACTIVE * V_ACTIVE / PIX_PER_WORD;

    vtc_sync_t sync;       // straight from the counters
    vtc_sync_t pix_sync;   // aligned with pix
    pixel_t    pix;
    pixel_t    threshold;

    video_timing_gen #(
        .H_ACTIVE (H_ACTIVE),
        .H_FP     (H_FP),
        .H_SYNC   (H_SYNC),
        .H_BP     (H_BP),
        .V_ACTIVE (V_ACTIVE),
        .V_FP     (V_FP),
        .V_SYNC   (V_SYNC),
        .V_BP     (V_BP)
    ) u_video_timing_gen (
        .vtc_clk  (vtc_clk),
        .arst_n_i (arst_n_i),
        .sync_o   (sync)
    );

    pixel_fetch #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .FRAME_WORDS (FRAME_WORDS)
    ) u_pixel_fetch (
        .vtc_clk    (vtc_clk),
        .arst_n_i   (arst_n_i),
        .sync_i     (sync),
        .wb_dat_i   (wb_dat_i),
        .wb_ack_i   (wb_ack_i),
        .wb_req_o   (wb_req_o),
        .sync_o     (pix_sync),
        .pix_o      (pix),
        .underrun_o (underrun_o)
    );

    threshold_ctrl u_threshold_ctrl (
        .vtc_clk     (vtc_clk),
        .arst_n_i    (arst_n_i),
        .key_i       (key_i),
        .threshold_o (threshold)
    );

    edge_overlay u_edge_overlay (
        .vtc_clk     (vtc_clk),
        .arst_n_i    (arst_n_i),
        .sync_i      (pix_sync),
        .pix_i       (pix),
        .threshold_i (threshold),
        .sync_o      (video_sync_o),
        .rgb_o       (video_rgb_o)
    );

endmodule

//--- verif/edge_video_sva.sv
`timescale 1ns/1ps

module edge_video_sva import video_pkg::*; (
    input logic      vtc_clk,
    input logic      arst_n_i,
    input wb_req_t   wb_req_o,
    input logic      wb_ack_i,
    input vtc_sync_t video_sync_o
);

    int assert_fails = 0;   // failures so far

    stb_needs_cyc: assert property (
        @(posedge vtc_clk) disable iff (!arst_n_i)
        wb_req_o.stb |-> wb_req_o.cyc
    ) else begin
        assert_fails++;
        $error("wishbone stb high without cyc");
    end

    // request held with a steady address until ack
    adr_held: assert property (
        @(posedge vtc_clk) disable iff (!arst_n_i)
        (wb_req_o.cyc && !wb_ack_i) |=> (wb_req_o.cyc && $stable(wb_req_o.adr))
    ) else begin
        assert_fails++;
        $error("wishbone request dropped or address changed before ack");
    end

    sof_in_vs: assert property (
        @(posedge vtc_clk) disable iff (!arst_n_i)
        video_sync_o.sof |-> video_sync_o.vs
    ) else begin
        assert_fails++;
        $error("sof outside vs");
    end

endmodule

bind edge_video_top edge_video_sva u_sva (.*);

//--- verif/edge_video_tb.sv
`timescale 1ns/1ps

module edge_video_tb
    import video_pkg::*;
();

    localparam int H_ACTIVE     = 16;
    localparam int H_FP         = 4;
    localparam int H_SYNC       = 2;
    localparam int H_BP         = 6;
    localparam int V_ACTIVE     = 4;
    localparam int V_FP         = 1;
    localparam int V_SYNC       = 1;
    localparam int V_BP         = 2;
    localparam int FRAME_PIX    = H_ACTIVE * V_ACTIVE;
    localparam int FRAME_WORDS  = FRAME_PIX / PIX_PER_WORD;
    localparam int LINE_CYCLES  = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int FRAME_LINES  = V_ACTIVE + V_FP + V_SYNC + V_BP;
    localparam int FRAME_CYCLES = LINE_CYCLES * FRAME_LINES;
    localparam int SOF_LINE     = V_ACTIVE + V_FP;   // sof opens the vs line
    localparam int RESET_CYCLES = 16;
    localparam int RUN_FRAMES   = 12;   // frames waited on by the sequence below
    localparam int LIMIT        = RESET_CYCLES + (RUN_FRAMES + 2) * FRAME_CYCLES;

    logic              vtc_clk;
    logic              arst_n_i;
    logic              key_i;
    logic [WORD_W-1:0] wb_dat_i = '0;
    logic              wb_ack_i = 1'b0;
    wb_req_t           wb_req_o;
    vtc_sync_t         video_sync_o;
    rgb_t              video_rgb_o;
    logic              underrun_o;

    logic [WORD_W-1:0] frame_mem [FRAME_WORDS];
    logic [31:0]       rng_state;
    int                errors;
    int                checks;
    int                err_mark;
    int                press_total;
    int                frames_done;
    int                cycles;
    logic              armed      = 1'b0;   // set at the first output sof
    logic              bus_armed  = 1'b0;
    logic              cyc_q      = 1'b0;
    logic              de_q       = 1'b0;
    logic              underrun_q = 1'b0;
    logic [WB_ADR_W-1:0] exp_adr;
    int                req_cnt;
    int                wait_left;
    int                pix_idx;
    int                de_cnt;
    int                lines;
    int                vs_cnt;
    int                frame_pos;
    pixel_t            exp_thr;

    edge_video_top #(
        .H_ACTIVE   (H_ACTIVE),
        .H_FP       (H_FP),
        .H_SYNC     (H_SYNC),
        .H_BP       (H_BP),
        .V_ACTIVE   (V_ACTIVE),
        .V_FP       (V_FP),
        .V_SYNC     (V_SYNC),
        .V_BP       (V_BP),
        .FIFO_DEPTH (4)
    ) uut (.*);

    initial begin
        vtc_clk = 1'b0;
        forever #50 vtc_clk = ~vtc_clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // key count wraps at 32, below 8 the default applies
    function automatic pixel_t thr_for(input int presses);
        key_state_t cnt;
        cnt = key_state_t'(presses % 32);
        return (cnt < 8) ? 8'd80 : pixel_t'(cnt) * 8'd8;
    endfunction

    function automatic pixel_t mem_pixel(input int idx);
        logic [WORD_W-1:0] word;
        word = frame_mem[idx / PIX_PER_WORD];
        return pixel_t'(word >> (8 * (PIX_PER_WORD - 1 - idx % PIX_PER_WORD)));   // msb first
    endfunction

    function automatic rgb_t expected_rgb(input int idx, input pixel_t thr);
        pixel_t cur;
        pixel_t prev2;
        pixel_t diff;
        pixel_t grey;
        cur   = mem_pixel(idx);
        prev2 = (idx % H_ACTIVE >= 2) ? mem_pixel(idx - 2) : 8'd0;   // line start sees zeros
        diff  = (cur >= prev2) ? cur - prev2 : prev2 - cur;
        grey  = (diff > thr) ? 8'hff : cur;
        return {grey, grey, grey};
    endfunction

    // sync expected a given number of cycles after the first output sof
    function automatic vtc_sync_t expected_sync(input int pos);
        vtc_sync_t s;
        int        h;
        int        v;
        h     = pos % LINE_CYCLES;
        v     = (SOF_LINE + (pos % FRAME_CYCLES) / LINE_CYCLES) % FRAME_LINES;
        s.de  = (h < H_ACTIVE) && (v < V_ACTIVE);
        s.hs  = (h >= H_ACTIVE + H_FP) && (h < H_ACTIVE + H_FP + H_SYNC);
        s.vs  = (v >= SOF_LINE) && (v < SOF_LINE + V_SYNC);
        s.sof = (pos % FRAME_CYCLES == 0);
        return s;
    endfunction

    function automatic int error_total();
        return errors + uut.u_sva.assert_fails;
    endfunction

    task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_sync(input string name, input vtc_sync_t got, input vtc_sync_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_adr(input string name, input logic [WB_ADR_W-1:0] got,
                             input logic [WB_ADR_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic press_key(input int n);
        repeat (n) begin
            @(posedge vtc_clk);
            key_i <= 1'b1;
            repeat (4) @(posedge vtc_clk);
            key_i <= 1'b0;
            repeat (3) @(posedge vtc_clk);
            press_total++;
        end
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = frames_done + n;
        while (frames_done < target) begin
            @(posedge vtc_clk);
        end
    endtask

    task automatic report_test(input string name);
        int now_errors;
        now_errors = error_total();
        if (now_errors == err_mark)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, now_errors - err_mark);
        err_mark = now_errors;
    endtask

    // wishbone memory with 0 to 3 wait states per read
    always @(posedge vtc_clk) begin
        if (arst_n_i) begin
            if (video_sync_o.sof) begin
                if (bus_armed && req_cnt != FRAME_WORDS) begin
                    errors++;
                    $display("frame fetch made %0d reads instead of %0d", req_cnt, FRAME_WORDS);
                end
                bus_armed = 1'b1;
                req_cnt   = 0;
                exp_adr   = '0;   // next frame starts over
            end
            if (wb_req_o.cyc && !cyc_q) begin
                check_adr("wb_req_o.adr", wb_req_o.adr, exp_adr);
                exp_adr++;
                req_cnt++;
                rng_state = lcg_next(rng_state);
                wait_left = rng_state[17:16];
            end
            cyc_q = wb_req_o.cyc;
            wb_ack_i <= 1'b0;
            if (wb_req_o.cyc && !wb_ack_i) begin
                if (wait_left == 0) begin
                    wb_ack_i <= 1'b1;
                    wb_dat_i <= frame_mem[wb_req_o.adr % FRAME_WORDS];
                end else begin
                    wait_left--;
                end
            end
        end
    end

    // output monitor, one frame runs from sof to sof
    always @(posedge vtc_clk) begin
        if (arst_n_i) begin
            if (video_sync_o.sof) begin
                if (armed) begin
                    checks++;
                    if (de_cnt != FRAME_PIX || lines != V_ACTIVE || vs_cnt != LINE_CYCLES) begin
                        errors++;
                        $display("frame %0d shape wrong: %0d de cycles, %0d lines, %0d vs cycles",
                                 frames_done, de_cnt, lines, vs_cnt);
                    end
                    frames_done <= frames_done + 1;
                end else begin
                    frame_pos = 0;   // timing is free running from here on
                end
                armed   = 1'b1;
                exp_thr = thr_for(press_total);   // latched like the DUT
                pix_idx = 0;
                de_cnt  = 0;
                lines   = 0;
                vs_cnt  = 0;
            end
            if (armed) begin
                check_sync("video_sync_o", video_sync_o, expected_sync(frame_pos));
                frame_pos++;
            end
            if (video_sync_o.de && !de_q)
                lines++;
            if (video_sync_o.vs)
                vs_cnt++;
            if (armed && video_sync_o.de) begin
                de_cnt++;
                if (pix_idx < FRAME_PIX)
                    check_rgb("video_rgb_o", video_rgb_o, expected_rgb(pix_idx, exp_thr));
                pix_idx++;
            end else if (armed) begin
                check_rgb("video_rgb_o", video_rgb_o, '0);   // blanked outside de
            end
            if (underrun_o && !underrun_q) begin
                errors++;
                $display("underrun_o went high in frame %0d", frames_done);
            end
            underrun_q = underrun_o;
            de_q       = video_sync_o.de;
        end
    end

    always @(posedge vtc_clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout, the run did not finish within %0d cycles", LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        arst_n_i  = 1'b0;
        key_i     = 1'b0;
        rng_state = 32'hf929;
        for (int a = 0; a < FRAME_WORDS; a++) begin
            rng_state    = lcg_next(rng_state);
            frame_mem[a] = rng_state;
        end
        repeat (RESET_CYCLES - 1) @(posedge vtc_clk);
        checks++;
        if (wb_req_o.cyc || wb_req_o.stb || underrun_o) begin
            errors++;
            $display("bus request or underrun active during reset");
        end
        check_sync("video_sync_o", video_sync_o, '0);
        check_rgb("video_rgb_o", video_rgb_o, '0);
        @(posedge vtc_clk);
        arst_n_i <= 1'b1;
        report_test("reset values");
        wait_frames(3);
        report_test("frames at threshold 80, bus order, no underrun");
        press_key(12);
        wait_frames(2);
        report_test("12 presses, threshold 96");
        press_key(8);
        wait_frames(2);
        report_test("20 presses, threshold 160");
        key_i <= 1'b1;   // one rising edge only
        press_total++;
        wait_frames(3);
        report_test("key held high, threshold stays 168");
        key_i <= 1'b0;
        repeat (4) @(posedge vtc_clk);
        press_key(11);
        wait_frames(2);
        report_test("32 presses, count wraps, threshold 80");
        $display("checks: %0d, errors: %0d", checks, error_total());
        if (error_total() == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

//--- verilog.f
rtl/video_pkg.sv
rtl/video_timing_gen.sv
rtl/pixel_fetch.sv
rtl/threshold_ctrl.sv
rtl/edge_overlay.sv
rtl/edge_video_top.sv
verif/edge_video_sva.sv
verif/edge_video_tb.sv

//--- Bender.yml
package:
  name: edge_video

sources:
  - rtl/video_pkg.sv
  - rtl/video_timing_gen.sv
  - rtl/pixel_fetch.sv
  - rtl/threshold_ctrl.sv
  - rtl/edge_overlay.sv
  - rtl/edge_video_top.sv
  - target: simulation
    files:
      - verif/edge_video_sva.sv
      - verif/edge_video_tb.sv
